// ==== all.f ====
design/noc_topology_pkg.sv
design/flit_format_pkg.sv
design/flit_fifo.sv
design/port_arbiter.sv
design/spidergon_router.sv
design/spidergon_top.sv
verification/tb_clock.sv
verification/spidergon_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run the testbench, decide the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module spidergon_tb -f all.f \
	&& ./obj_dir/Vspidergon_tb > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/spidergon_tb.sv ====
// self-checking testbench for the spidergon network, run as the simulation top with all.f
module spidergon_tb;

	import noc_topology_pkg::*;
	import flit_format_pkg::*;

	localparam int NUM_OF_NODES = DEFAULT_NUM_OF_NODES;
	localparam int DATA_WIDTH = DEFAULT_FLIT_DATA_WIDTH;
	localparam int FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
	localparam int NODE_BITS = $clog2(NUM_OF_NODES);
	localparam int FLIT_WIDTH = 2 * NODE_BITS + DATA_WIDTH;

	// low payload bits hold a sequence number, the rest is a free tag
	localparam int SEQ_BITS = 10;
	localparam int SEQ_SPACE = 1 << SEQ_BITS;
	localparam int TAG_BITS = DATA_WIDTH - SEQ_BITS;

	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 2;
	localparam int IDLE_CYCLES = 10;
	localparam int SINGLE_WAIT = 10;
	localparam int SINGLE_SPACING = 2 + SINGLE_WAIT;
	localparam int DRAIN_CYCLES = 40;
	localparam int RANDOM_PACKETS = 200;
	localparam int HOTSPOT_NODE = 3 % NUM_OF_NODES;
	localparam int HOTSPOT_ROUNDS = 8;

	// each test gets its injections plus a drain allowance
	localparam int CYCLE_LIMIT = RESET_CYCLES + IDLE_CYCLES
		+ NUM_OF_NODES * SINGLE_SPACING + DRAIN_CYCLES
		+ NUM_OF_NODES * SINGLE_SPACING + DRAIN_CYCLES
		+ NUM_OF_NODES * NUM_OF_NODES * 2 + DRAIN_CYCLES
		+ RANDOM_PACKETS * 2 + DRAIN_CYCLES
		+ (NUM_OF_NODES - 1) * HOTSPOT_ROUNDS * 2 + DRAIN_CYCLES;

	logic clk;
	logic reset;
	logic inject_valid;
	logic [NODE_BITS-1:0] inject_node;
	logic [NODE_BITS-1:0] inject_dest;
	logic [DATA_WIDTH-1:0] inject_payload;
	logic [NUM_OF_NODES-1:0] eject_valid;
	logic [NUM_OF_NODES*FLIT_WIDTH-1:0] eject_flit;

	int cycle;
	logic [31:0] lfsr_state;
	string test_name;
	int test_errors;
	int tests_passed;
	int tests_failed;
	int next_seq;
	int pending_count;

	// packets in flight by sequence number
	bit pending [SEQ_SPACE];
	int expected_node [SEQ_SPACE];
	logic [FLIT_WIDTH-1:0] expected_flit [SEQ_SPACE];
	int expected_latency [SEQ_SPACE];
	int inject_cycle [SEQ_SPACE];
	bit timed [SEQ_SPACE];

	tb_clock #(
		.PERIOD(40)
	) clock_gen (
		.clk(clk)
	);

	spidergon_top #(
		.NUM_OF_NODES(NUM_OF_NODES),
		.FLIT_DATA_WIDTH(DATA_WIDTH),
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.clk(clk),
		.reset(reset),
		.inject_valid(inject_valid),
		.inject_node(inject_node),
		.inject_dest(inject_dest),
		.inject_payload(inject_payload),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit)
	);

	// 32-bit fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	// walks the route hop by hop with the distance rule and predicts the ejection
	function automatic void predict_delivery(input int src, input int dst,
		input logic [DATA_WIDTH-1:0] payload, output int eject_node,
		output logic [FLIT_WIDTH-1:0] flit, output int latency);
		int node;
		int hops;
		int distance;
		node = src;
		hops = 0;
		while (node != dst && hops < NUM_OF_NODES)
		begin
			distance = (dst - node + NUM_OF_NODES) % NUM_OF_NODES;
			if (4 * distance <= NUM_OF_NODES)
			begin
				node = (node + 1) % NUM_OF_NODES;
			end
			else if (4 * distance >= 3 * NUM_OF_NODES)
			begin
				node = (node + NUM_OF_NODES - 1) % NUM_OF_NODES;
			end
			else
			begin
				node = (node + NUM_OF_NODES / 2) % NUM_OF_NODES;
			end
			hops++;
		end
		eject_node = dst;
		flit = {NODE_BITS'(dst), NODE_BITS'(src), payload};
		// buffer write plus output register on every router passed
		latency = 2 * (hops + 1);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic close_test();
		if (test_errors == 0)
		begin
			$display("test %s: pass", test_name);
			tests_passed++;
		end
		else
		begin
			$display("test %s: fail with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// one strobe, then one idle cycle, so at most one injection every 2 cycles
	task automatic send_packet(input int src, input int dst, input int tag,
		input bit check_latency);
		int seq;
		int eject_node;
		int latency;
		logic [FLIT_WIDTH-1:0] flit;
		logic [DATA_WIDTH-1:0] payload;
		seq = next_seq % SEQ_SPACE;
		next_seq++;
		payload = DATA_WIDTH'((tag % (1 << TAG_BITS)) * SEQ_SPACE + seq);
		predict_delivery(src, dst, payload, eject_node, flit, latency);
		pending[seq] = 1'b1;
		expected_node[seq] = eject_node;
		expected_flit[seq] = flit;
		expected_latency[seq] = latency;
		inject_cycle[seq] = cycle;
		timed[seq] = check_latency;
		pending_count++;
		inject_valid = 1'b1;
		inject_node = NODE_BITS'(src);
		inject_dest = NODE_BITS'(dst);
		inject_payload = payload;
		next_cycle();
		inject_valid = 1'b0;
		next_cycle();
	endtask

	task automatic wait_for_delivery(input int limit);
		int waited;
		waited = 0;
		while (pending_count != 0 && waited < limit)
		begin
			next_cycle();
			waited++;
		end
		if (pending_count != 0)
		begin
			$display("%s: %0d packets were never delivered within %0d cycles",
				test_name, pending_count, limit);
			test_errors++;
			for (int i = 0; i < SEQ_SPACE; i++)
			begin
				pending[i] = 1'b0;
			end
			pending_count = 0;
		end
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	// ejections are sampled half a cycle after the edge that registers them
	always @(negedge clk)
	begin
		logic [FLIT_WIDTH-1:0] flit;
		int seq;
		if (!reset)
		begin
			for (int n = 0; n < NUM_OF_NODES; n++)
			begin
				if (eject_valid[n])
				begin
					flit = eject_flit[n*FLIT_WIDTH +: FLIT_WIDTH];
					seq = int'(flit[SEQ_BITS-1:0]);
					if (!pending[seq])
					begin
						$display("%s: unexpected or duplicate packet ejected at node %0d, flit %h",
							test_name, n, flit);
						test_errors++;
					end
					else
					begin
						if (n != expected_node[seq])
						begin
							$display("error: %s eject node expected %0d actual %0d",
								test_name, expected_node[seq], n);
							test_errors++;
						end
						if (flit != expected_flit[seq])
						begin
							$display("error: %s flit expected %h actual %h",
								test_name, expected_flit[seq], flit);
							test_errors++;
						end
						if (timed[seq] && (cycle - inject_cycle[seq] != expected_latency[seq]))
						begin
							$display("error: %s latency expected %0d actual %0d",
								test_name, expected_latency[seq], cycle - inject_cycle[seq]);
							test_errors++;
						end
						pending[seq] = 1'b0;
						pending_count--;
					end
				end
			end
		end
	end

	// watchdog
	initial
	begin
		wait (cycle >= CYCLE_LIMIT);
		$display("run stopped: the cycle limit of %0d was reached before the tests finished",
			CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		int src;
		int dst;
		int tag;
		reset = 1'b1;
		inject_valid = 1'b0;
		inject_node = '0;
		inject_dest = '0;
		inject_payload = '0;
		lfsr_state = 32'h4f87;
		test_name = "setup";
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		open_test("reset");
		for (int i = 0; i < IDLE_CYCLES; i++)
		begin
			next_cycle();
			if (eject_valid !== '0)
			begin
				$display("error: %s eject_valid expected %h actual %h", test_name,
					{NUM_OF_NODES{1'b0}}, eject_valid);
				test_errors++;
			end
		end
		close_test();

		// one packet alone in the network, so latency is exact
		open_test("single_packet");
		for (int d = 0; d < NUM_OF_NODES; d++)
		begin
			send_packet(0, d, d + 1, 1'b1);
			wait_for_delivery(SINGLE_WAIT);
		end
		close_test();

		open_test("self_addressed");
		for (int n = 0; n < NUM_OF_NODES; n++)
		begin
			send_packet(n, n, 2 * n + 3, 1'b1);
			wait_for_delivery(SINGLE_WAIT);
		end
		close_test();

		open_test("all_pairs");
		for (int s = 0; s < NUM_OF_NODES; s++)
		begin
			for (int d = 0; d < NUM_OF_NODES; d++)
			begin
				send_packet(s, d, s * NUM_OF_NODES + d, 1'b0);
			end
		end
		wait_for_delivery(DRAIN_CYCLES);
		close_test();

		open_test("random_traffic");
		for (int i = 0; i < RANDOM_PACKETS; i++)
		begin
			draw_bits(NODE_BITS, src);
			draw_bits(NODE_BITS, dst);
			draw_bits(TAG_BITS, tag);
			send_packet(src % NUM_OF_NODES, dst % NUM_OF_NODES, tag, 1'b0);
		end
		wait_for_delivery(DRAIN_CYCLES);
		close_test();

		// every other node aims at one ejection port
		open_test("hotspot");
		for (int r = 0; r < HOTSPOT_ROUNDS; r++)
		begin
			for (int s = 0; s < NUM_OF_NODES; s++)
			begin
				if (s != HOTSPOT_NODE)
				begin
					send_packet(s, HOTSPOT_NODE, r, 1'b0);
				end
			end
		end
		wait_for_delivery(DRAIN_CYCLES);
		close_test();

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("All tests passed");
		end
		else
		begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verification/tb_clock.sv ====
// free-running testbench clock, instantiated once by the testbench top
module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

// ==== design/spidergon_top.sv ====
// spidergon network top level that wires the router ring, across links, injection and ejection
module spidergon_top #(
	parameter int NUM_OF_NODES = noc_topology_pkg::DEFAULT_NUM_OF_NODES,
	parameter int FLIT_DATA_WIDTH = flit_format_pkg::DEFAULT_FLIT_DATA_WIDTH,
	parameter int FIFO_DEPTH = flit_format_pkg::DEFAULT_FIFO_DEPTH,
	localparam int NODE_BITS = flit_format_pkg::node_width(NUM_OF_NODES),
	localparam int FLIT_WIDTH = flit_format_pkg::flit_width(NUM_OF_NODES, FLIT_DATA_WIDTH)
) (
	input  logic clk,
	input  logic reset,

	// one injection strobe for the whole network, inject_node picks the source
	input  logic inject_valid,
	input  logic [NODE_BITS-1:0] inject_node,
	input  logic [NODE_BITS-1:0] inject_dest,
	input  logic [FLIT_DATA_WIDTH-1:0] inject_payload,

	// node n ejects on bit n and on slice n of the flit bus
	output logic [NUM_OF_NODES-1:0] eject_valid,
	output logic [NUM_OF_NODES*FLIT_WIDTH-1:0] eject_flit
);

	import noc_topology_pkg::*;

	// registered router outputs indexed by node then by link port
	logic link_valid [NUM_OF_NODES][NUM_OF_PORTS-1];
	logic [FLIT_WIDTH-1:0] link_flit [NUM_OF_NODES][NUM_OF_PORTS-1];

	// injected word with the destination on top, then the source and the payload
	logic [FLIT_WIDTH-1:0] inject_flit;

	assign inject_flit = {inject_dest, inject_node, inject_payload};

	for (genvar n = 0; n < NUM_OF_NODES; n++)
	begin : node
		// neighbours of node n on the ring
		localparam int NEXT_NODE = (n + 1) % NUM_OF_NODES;
		localparam int PREV_NODE = (n + NUM_OF_NODES - 1) % NUM_OF_NODES;
		localparam int ACROSS_NODE = (n + NUM_OF_NODES / 2) % NUM_OF_NODES;

		logic local_valid;

		// only the named source node sees the strobe
		assign local_valid = inject_valid && (inject_node == NODE_BITS'(n));

		spidergon_router #(
			.NUM_OF_NODES(NUM_OF_NODES),
			.FLIT_DATA_WIDTH(FLIT_DATA_WIDTH),
			.FIFO_DEPTH(FIFO_DEPTH),
			.NODE_ID(n)
		) router (
			.clk(clk),
			.reset(reset),

			// anti-clockwise input is fed by the clockwise output of node n-1
			.in_valid_anticlockwise(link_valid[PREV_NODE][PORT_CLOCKWISE]),
			.in_flit_anticlockwise(link_flit[PREV_NODE][PORT_CLOCKWISE]),
			// clockwise input is fed by the anti-clockwise output of node n+1
			.in_valid_clockwise(link_valid[NEXT_NODE][PORT_ANTI_CLOCKWISE]),
			.in_flit_clockwise(link_flit[NEXT_NODE][PORT_ANTI_CLOCKWISE]),
			.in_valid_across(link_valid[ACROSS_NODE][PORT_ACROSS]),
			.in_flit_across(link_flit[ACROSS_NODE][PORT_ACROSS]),
			.inject_valid(local_valid),
			.inject_flit(inject_flit),

			.out_valid_anticlockwise(link_valid[n][PORT_ANTI_CLOCKWISE]),
			.out_flit_anticlockwise(link_flit[n][PORT_ANTI_CLOCKWISE]),
			.out_valid_clockwise(link_valid[n][PORT_CLOCKWISE]),
			.out_flit_clockwise(link_flit[n][PORT_CLOCKWISE]),
			.out_valid_across(link_valid[n][PORT_ACROSS]),
			.out_flit_across(link_flit[n][PORT_ACROSS]),
			.eject_valid(eject_valid[n]),
			.eject_flit(eject_flit[n*FLIT_WIDTH +: FLIT_WIDTH])
		);
	end

endmodule

// ==== design/spidergon_router.sv ====
// router of one spidergon node that the top level instantiates once per node
module spidergon_router #(
	parameter int NUM_OF_NODES = noc_topology_pkg::DEFAULT_NUM_OF_NODES,
	parameter int FLIT_DATA_WIDTH = flit_format_pkg::DEFAULT_FLIT_DATA_WIDTH,
	parameter int FIFO_DEPTH = flit_format_pkg::DEFAULT_FIFO_DEPTH,
	parameter int NODE_ID = 0,
	localparam int NODE_BITS = flit_format_pkg::node_width(NUM_OF_NODES),
	localparam int FLIT_WIDTH = flit_format_pkg::flit_width(NUM_OF_NODES, FLIT_DATA_WIDTH)
) (
	input  logic clk,
	input  logic reset,

	input  logic in_valid_anticlockwise,
	input  logic [FLIT_WIDTH-1:0] in_flit_anticlockwise,
	input  logic in_valid_clockwise,
	input  logic [FLIT_WIDTH-1:0] in_flit_clockwise,
	input  logic in_valid_across,
	input  logic [FLIT_WIDTH-1:0] in_flit_across,
	input  logic inject_valid,
	input  logic [FLIT_WIDTH-1:0] inject_flit,

	output logic out_valid_anticlockwise,
	output logic [FLIT_WIDTH-1:0] out_flit_anticlockwise,
	output logic out_valid_clockwise,
	output logic [FLIT_WIDTH-1:0] out_flit_clockwise,
	output logic out_valid_across,
	output logic [FLIT_WIDTH-1:0] out_flit_across,
	output logic eject_valid,
	output logic [FLIT_WIDTH-1:0] eject_flit
);

	import noc_topology_pkg::*;

	// inputs gathered by port index
	logic in_valid [NUM_OF_PORTS];
	logic [FLIT_WIDTH-1:0] in_flit [NUM_OF_PORTS];

	// buffer heads and the output each one wants
	logic head_valid [NUM_OF_PORTS];
	logic [FLIT_WIDTH-1:0] head_flit [NUM_OF_PORTS];
	int distance [NUM_OF_PORTS];
	logic [1:0] route [NUM_OF_PORTS];
	logic [NUM_OF_PORTS-1:0] pop;

	// request and grant vectors indexed by output then by input
	logic [NUM_OF_PORTS-1:0] request [NUM_OF_PORTS];
	logic [NUM_OF_PORTS-1:0] grant [NUM_OF_PORTS];
	logic [FLIT_WIDTH-1:0] selected [NUM_OF_PORTS];

	// registered outputs indexed by output port
	logic out_valid [NUM_OF_PORTS];
	logic [FLIT_WIDTH-1:0] out_flit [NUM_OF_PORTS];

	assign in_valid[PORT_ANTI_CLOCKWISE] = in_valid_anticlockwise;
	assign in_flit[PORT_ANTI_CLOCKWISE] = in_flit_anticlockwise;
	assign in_valid[PORT_CLOCKWISE] = in_valid_clockwise;
	assign in_flit[PORT_CLOCKWISE] = in_flit_clockwise;
	assign in_valid[PORT_ACROSS] = in_valid_across;
	assign in_flit[PORT_ACROSS] = in_flit_across;
	assign in_valid[PORT_LOCAL] = inject_valid;
	assign in_flit[PORT_LOCAL] = inject_flit;

	for (genvar p = 0; p < NUM_OF_PORTS; p++)
	begin : input_port
		flit_fifo #(
			.FLIT_WIDTH(FLIT_WIDTH),
			.FIFO_DEPTH(FIFO_DEPTH)
		) buffer (
			.clk(clk),
			.reset(reset),
			.write_valid(in_valid[p]),
			.write_flit(in_flit[p]),
			.pop(pop[p]),
			.head_valid(head_valid[p]),
			.head_flit(head_flit[p])
		);

		// hops left measured clockwise from this node
		assign distance[p] = (int'(head_flit[p][FLIT_WIDTH-1 -: NODE_BITS]) + NUM_OF_NODES
			- NODE_ID) % NUM_OF_NODES;

		// quarter limits scaled by 4 to stay exact for any even ring size
		assign route[p] = (distance[p] == 0) ? PORT_LOCAL :
			(4 * distance[p] <= NUM_OF_NODES) ? PORT_CLOCKWISE :
			(4 * distance[p] >= 3 * NUM_OF_NODES) ? PORT_ANTI_CLOCKWISE : PORT_ACROSS;
	end

	always_comb
	begin
		for (int o = 0; o < NUM_OF_PORTS; o++)
		begin
			for (int i = 0; i < NUM_OF_PORTS; i++)
			begin
				request[o][i] = head_valid[i] && (int'(route[i]) == o);
			end
		end
	end

	for (genvar o = 0; o < NUM_OF_PORTS; o++)
	begin : output_port
		port_arbiter arbiter (
			.clk(clk),
			.reset(reset),
			.request(request[o]),
			.grant(grant[o])
		);
	end

	// an input is routed to one output only, so at most one grant per input
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < NUM_OF_PORTS; o++)
		begin
			pop = pop | grant[o];
		end
	end

	// one-hot grant selects the flit for each output
	always_comb
	begin
		for (int o = 0; o < NUM_OF_PORTS; o++)
		begin
			selected[o] = '0;
			for (int i = 0; i < NUM_OF_PORTS; i++)
			begin
				if (grant[o][i])
				begin
					selected[o] = head_flit[i];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_OF_PORTS; o++)
		begin
			if (reset)
			begin
				out_valid[o] <= 1'b0;
			end
			else
			begin
				out_valid[o] <= |grant[o];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_OF_PORTS; o++)
		begin
			out_flit[o] <= selected[o];
		end
	end

	assign out_valid_anticlockwise = out_valid[PORT_ANTI_CLOCKWISE];
	assign out_flit_anticlockwise = out_flit[PORT_ANTI_CLOCKWISE];
	assign out_valid_clockwise = out_valid[PORT_CLOCKWISE];
	assign out_flit_clockwise = out_flit[PORT_CLOCKWISE];
	assign out_valid_across = out_valid[PORT_ACROSS];
	assign out_flit_across = out_flit[PORT_ACROSS];
	assign eject_valid = out_valid[PORT_LOCAL];
	assign eject_flit = out_flit[PORT_LOCAL];

endmodule

// ==== design/port_arbiter.sv ====
// round-robin arbiter choosing one of the router inputs that compete for a single output
module port_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic [noc_topology_pkg::NUM_OF_PORTS-1:0] request,
	output logic [noc_topology_pkg::NUM_OF_PORTS-1:0] grant
);

	import noc_topology_pkg::*;

	localparam int PTR_WIDTH = $clog2(NUM_OF_PORTS);

	// input with the highest priority in the current cycle
	logic [PTR_WIDTH-1:0] pointer;
	logic [PTR_WIDTH-1:0] candidate;
	logic [PTR_WIDTH-1:0] winner;
	logic found;

	// scan from the pointer around all inputs, first requester wins
	always_comb
	begin
		grant = '0;
		winner = pointer;
		found = 1'b0;
		candidate = pointer;
		for (int i = 0; i < NUM_OF_PORTS; i++)
		begin
			candidate = PTR_WIDTH'((int'(pointer) + i) % int'(NUM_OF_PORTS));
			if (!found && request[candidate])
			begin
				found = 1'b1;
				winner = candidate;
			end
		end
		if (found)
		begin
			grant[winner] = 1'b1;
		end
	end

	// the winner drops to lowest priority for the next round
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pointer <= '0;
		end
		else if (found)
		begin
			pointer <= PTR_WIDTH'((int'(winner) + 1) % int'(NUM_OF_PORTS));
		end
	end

endmodule

// ==== design/flit_fifo.sv ====
// first-word-fall-through buffer for one router input, the oldest flit is always shown at the head
module flit_fifo #(
	parameter int FLIT_WIDTH = flit_format_pkg::flit_width(
		noc_topology_pkg::DEFAULT_NUM_OF_NODES, flit_format_pkg::DEFAULT_FLIT_DATA_WIDTH),
	parameter int FIFO_DEPTH = flit_format_pkg::DEFAULT_FIFO_DEPTH
) (
	input  logic clk,
	input  logic reset,
	input  logic write_valid,
	input  logic [FLIT_WIDTH-1:0] write_flit,
	input  logic pop,
	output logic head_valid,
	output logic [FLIT_WIDTH-1:0] head_flit
);

	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	logic [FLIT_WIDTH-1:0] storage [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic full;
	logic do_write;
	logic do_pop;

	assign full = (count == COUNT_WIDTH'(FIFO_DEPTH));

	// a write into a full buffer is dropped
	assign do_write = write_valid && !full;
	assign do_pop = pop && head_valid;

	assign head_valid = (count != '0);
	assign head_flit = storage[read_ptr];

	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			storage[write_ptr] <= write_flit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
			begin
				// wrap by compare so depths other than a power of two work too
				write_ptr <= (write_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : write_ptr + 1'b1;
			end
			if (do_pop)
			begin
				read_ptr <= (read_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : read_ptr + 1'b1;
			end
			if (do_write && !do_pop)
			begin
				count <= count + 1'b1;
			end
			else if (do_pop && !do_write)
			begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== design/flit_format_pkg.sv ====
// flit field widths and field order shared by the buffers, routers, top and testbench
package flit_format_pkg;

	// payload bits carried by every flit
	localparam int DEFAULT_FLIT_DATA_WIDTH = 16;

	// entries in each router input buffer
	localparam int DEFAULT_FIFO_DEPTH = 8;

	// a packet is a single flit, fields from the top bit down
	//   destination node  [W-1 -: node_width]
	//   source node       [W-1-node_width -: node_width]
	//   payload           [data_width-1:0]
	// with W = 2*node_width + data_width, 22 bits for 8 nodes and 16 data bits

	// bits needed to name one node
	function automatic int node_width(input int num_of_nodes);
		return $clog2(num_of_nodes);
	endfunction

	// whole flit word
	function automatic int flit_width(input int num_of_nodes, input int data_width);
		return 2 * node_width(num_of_nodes) + data_width;
	endfunction

	// offset of the lowest source bit, the payload sits below it
	function automatic int source_lsb(input int data_width);
		return data_width;
	endfunction

endpackage

// ==== design/noc_topology_pkg.sv ====
// port numbering and ring defaults of the spidergon network, imported by routers, top and testbench
package noc_topology_pkg;

	// every router has the same four ports, numbered the same way on the
	// input side and on the output side

	// link towards node n-1, and the input fed by node n-1
	localparam logic [1:0] PORT_ANTI_CLOCKWISE = 2'd0;

	// link towards node n+1, and the input fed by node n+1
	localparam logic [1:0] PORT_CLOCKWISE = 2'd1;

	// link to the node half the ring away, in both directions
	localparam logic [1:0] PORT_ACROSS = 2'd2;

	// injection on the input side, ejection on the output side
	localparam logic [1:0] PORT_LOCAL = 2'd3;

	// three links plus the local port
	localparam logic [2:0] NUM_OF_PORTS = 3'd4;

	// ring size used by the top level unless overridden
	// must be even and at least 4 so that every node has an across partner
	localparam int unsigned DEFAULT_NUM_OF_NODES = 8;

	// link wiring around the ring, all indices modulo the node count
	//   clockwise output of node n     -> anti-clockwise input of node n+1
	//   anti-clockwise output of node n -> clockwise input of node n-1
	//   across output of node n        -> across input of node n+N/2

	// routing on the relative distance d = (destination - node) mod N
	//   d == 0            eject
	//   d <= N/4          clockwise
	//   d >= 3N/4         anti-clockwise
	//   otherwise         across
	// applied at every hop this reaches any node in at most 2 hops

endpackage
